// File: compile.f
hw/zports_pkg.sv
hw/port_bus_if.sv
hw/port_decode.sv
hw/port_regs.sv
hw/port_readback.sv
hw/zports_top.sv
testbench/zports_properties.sv
testbench/tb_zports.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the zports testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert \
	--top-module tb_zports \
	-f compile.f \
	-o tb_zports

# keep going after a property failure so the testbench prints its verdict
./obj_dir/tb_zports +verilator+error+limit+1000 | tee sim.log

if grep -q "Result: PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: testbench/tb_zports.sv
`timescale 1ns/10ps

module tb_zports
	import zports_pkg::*;
();

	localparam int          CLK_PERIOD      = 40;
	localparam int          TEST_COUNT      = 6;
	localparam int          CYCLES_PER_TEST = 200;
	localparam logic [31:0] SEED            = 32'hfdedecc2;

	logic        clk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic [4:0]  keys_in;
	logic [7:0]  mus_in;
	logic [7:0]  sd_dataout;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [5:0]  border;
	logic [7:0]  vcfg;
	logic [7:0]  psd0;
	logic [7:0]  psd1;
	logic [7:0]  psd2;
	logic [7:0]  psd3;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;

	int err_count   = 0;
	int check_count = 0;
	int test_count  = 0;
	int test_errs   = 0;
	int pulse_count = 0; // sd_start cycles seen so far

	zports_top UUT
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.a          (a),
		.din        (din),
		.iorq_n     (iorq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.keys_in    (keys_in),
		.mus_in     (mus_in),
		.sd_dataout (sd_dataout),
		.dout       (dout),
		.dataout    (dataout),
		.porthit    (porthit),
		.border     (border),
		.vcfg       (vcfg),
		.psd0       (psd0),
		.psd1       (psd1),
		.psd2       (psd2),
		.psd3       (psd3),
		.p7ffd      (p7ffd),
		.peff7      (peff7),
		.sdcs_n     (sdcs_n),
		.sd_start   (sd_start),
		.sd_datain  (sd_datain)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (sd_start)
			pulse_count <= pulse_count + 1;
	end

	// worst case budget for all tests
	initial
	begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles each", CYCLES_PER_TEST);
		$display("Result: FAILED");
		$finish;
	end

	task automatic check_eq(input logic [7:0] got, input logic [7:0] exp, input string what);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == test_errs)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_errs);
		test_errs = err_count;
	endtask

	// iorq_n low for 3 clocks, then idle for 1
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(negedge clk);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		@(negedge clk);
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] rd,
		output logic de, output logic ph);
		@(negedge clk);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		@(posedge clk); // bus settled half a clock ago
		rd = dout;
		de = dataout;
		ph = porthit;
		repeat (3) @(negedge clk);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		@(negedge clk);
	endtask

	initial
	begin
		logic [7:0] d;
		logic [7:0] v;
		logic [7:0] w;
		logic [7:0] rd;
		logic       de;
		logic       ph;
		int         pulses;

		void'($urandom(SEED));
		rst_n      = 1'b0;
		a          = '0;
		din        = '0;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		keys_in    = '0;
		mus_in     = '0;
		sd_dataout = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		keys_in = 5'($urandom);
		mus_in  = 8'($urandom);
		io_read({8'h00, PORT_FE}, rd, de, ph);
		check_eq(rd, {3'b100, keys_in}, "FE read");
		check_bit(de, 1'b1, "dataout on FE read");
		io_read({8'h00, PORT_MOUSE}, rd, de, ph);
		check_eq(rd, mus_in, "DF read");
		check_bit(de, 1'b1, "dataout on DF read");
		io_read(16'h00A3, rd, de, ph); // nothing lives at A3
		check_eq(rd, 8'hFF, "unused port read");
		check_bit(ph, 1'b0, "porthit on unused port");
		check_bit(de, 1'b0, "dataout on unused port");
		end_test("port reads");

		d = 8'($urandom) | 8'h10; // beeper high so the DACs leave 00
		io_write({8'h00, PORT_FE}, d);
		check_eq({2'b00, border}, {2'b00, d[1], 1'b0, d[2], 1'b0, d[0], 1'b0}, "border");
		check_eq(psd0, {8{d[4]}}, "psd0 beeper");
		check_eq(psd1, {8{d[4]}}, "psd1 beeper");
		check_eq(psd2, {8{d[4]}}, "psd2 beeper");
		check_eq(psd3, {8{d[4]}}, "psd3 beeper");
		end_test("FE write");

		v = 8'($urandom);
		io_write({8'h00, PORT_CVX1}, v);
		check_eq(psd1, v, "psd1 after FB");
		check_eq(psd2, v, "psd2 after FB");
		w = ~v;
		io_write({8'h00, PORT_CVX2}, w);
		check_eq(psd0, w, "psd0 after DD");
		check_eq(psd3, w, "psd3 after DD");
		io_write({8'h00, PORT_SD0}, v);
		check_eq(psd0, v, "psd0 after 0F");
		check_eq(psd1, w, "psd1 after 0F");
		io_write({8'h00, PORT_SD1}, v);
		check_eq(psd1, v, "psd1 after 1F");
		check_eq(psd2, w, "psd2 after 1F");
		io_write({8'h00, PORT_SD2}, v);
		check_eq(psd2, v, "psd2 after 4F");
		check_eq(psd3, w, "psd3 after 4F");
		io_write({8'h00, PORT_SD3}, v);
		check_eq(psd3, v, "psd3 after 5F");
		end_test("DAC writes");

		d = 8'($urandom) & 8'hDF; // lock bit clear
		io_write(16'h7FFD, d);
		check_eq(p7ffd, d, "p7ffd stored");
		v = 8'($urandom) | 8'h04;
		io_write(16'hEFF7, v);
		check_eq(peff7, v & 8'hB1, "peff7 masked");
		w = 8'($urandom) | 8'h20;
		io_write(16'h7FFD, w);
		check_eq(p7ffd, {3'b000, w[4:0]}, "p7ffd with lock set");
		io_write(16'h7FFD, w ^ 8'h1F);
		check_eq(p7ffd, {3'b000, w[4:0]}, "p7ffd while locked");
		end_test("7FFD lock");

		v = 8'($urandom);
		io_write(XT_PORT, XT_KEY);
		io_write(XT_PORT, XREG_VCFG);
		io_write(XT_PORT, v);
		check_eq(vcfg, v, "vcfg via 55FF");
		d = 8'($urandom);
		io_write(XT_PORT, XT_KEY);
		io_write(XT_PORT, XREG_BORDER);
		io_write(XT_PORT, d);
		check_eq({2'b00, border}, {2'b00, d[5:0]}, "border via 55FF");
		io_read({8'h00, PORT_XTRD}, rd, de, ph);
		check_eq(rd, {2'b00, d[5:0]}, "EF read");
		check_bit(de, 1'b1, "dataout on EF read");
		io_write(XT_PORT, XT_KEY);
		io_write({8'h00, PORT_FE}, 8'($urandom)); // breaks the sequence
		io_write(XT_PORT, XREG_VCFG);
		io_write(XT_PORT, ~v);
		check_eq(vcfg, v, "vcfg after broken sequence");
		end_test("extension port");

		io_write({8'h00, PORT_SDCFG}, 8'($urandom) & 8'hFD);
		check_bit(sdcs_n, 1'b0, "sdcs_n low");
		io_write({8'h00, PORT_SDCFG}, 8'($urandom) | 8'h02);
		check_bit(sdcs_n, 1'b1, "sdcs_n high");
		d      = 8'($urandom);
		pulses = pulse_count;
		io_write({8'h00, PORT_SDDAT}, d);
		check_bit(pulse_count == pulses + 1, 1'b1, "single sd_start on write");
		check_eq(sd_datain, d, "sd_datain on write");
		sd_dataout = 8'($urandom);
		pulses     = pulse_count;
		io_read({8'h00, PORT_SDDAT}, rd, de, ph);
		check_bit(pulse_count == pulses + 1, 1'b1, "single sd_start on read");
		check_eq(sd_datain, 8'hFF, "sd_datain on read");
		check_eq(rd, sd_dataout, "SDDAT read");
		check_bit(de, 1'b1, "dataout on SDDAT read");
		end_test("SD ports");

		$display("%0d tests, %0d checks, %0d errors, %0d property failures",
			test_count, check_count, err_count, UUT.u_props.fail_count);
		if (err_count == 0 && UUT.u_props.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: testbench/zports_properties.sv
`timescale 1ns/10ps

module zports_properties
(
	input logic clk,
	input logic rst_n,
	input logic dataout,
	input logic porthit,
	input logic sdcs_n,
	input logic sd_start
);

	int fail_count = 0;

	// SD start is a single clock pulse
	sd_start_single: assert property (@(posedge clk) disable iff (!rst_n)
		sd_start |=> !sd_start)
	else
	begin
		$error("sd_start stayed high for two cycles");
		fail_count++;
	end

	dataout_decoded: assert property (@(posedge clk) disable iff (!rst_n)
		dataout |-> porthit) // only decoded ports drive the bus
	else
	begin
		$error("dataout high without porthit");
		fail_count++;
	end

	sdcs_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> sdcs_n)
	else
	begin
		$error("sdcs_n not deasserted after reset");
		fail_count++;
	end

endmodule

bind zports_top zports_properties u_props
(
	.clk      (clk),
	.rst_n    (rst_n),
	.dataout  (dataout),
	.porthit  (porthit),
	.sdcs_n   (sdcs_n),
	.sd_start (sd_start)
);

// File: hw/zports_top.sv
`timescale 1ns/10ps

module zports_top
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [4:0]  keys_in,     // FE keyboard columns
	input  logic [7:0]  mus_in,      // DF mouse
	input  logic [7:0]  sd_dataout,  // from SPI
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic [5:0]  border,
	output logic [7:0]  vcfg,
	output logic [7:0]  psd0,
	output logic [7:0]  psd1,
	output logic [7:0]  psd2,
	output logic [7:0]  psd3,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain
);

	logic [7:0] xt_addr;

	port_bus_if bus ();

	port_decode u_decode
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.a       (a),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.din     (din),
		.porthit (porthit),
		.bus     (bus.dec)
	);

	port_regs u_regs
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.bus       (bus.exe),
		.border    (border),
		.vcfg      (vcfg),
		.psd0      (psd0),
		.psd1      (psd1),
		.psd2      (psd2),
		.psd3      (psd3),
		.p7ffd     (p7ffd),
		.peff7     (peff7),
		.sdcs_n    (sdcs_n),
		.sd_start  (sd_start),
		.sd_datain (sd_datain),
		.xt_addr   (xt_addr)
	);

	port_readback u_readback
	(
		.bus        (bus.res),
		.keys_in    (keys_in),
		.mus_in     (mus_in),
		.sd_dataout (sd_dataout),
		.border     (border),
		.xt_addr    (xt_addr),
		.iorq_n     (iorq_n),
		.rd_n       (rd_n),
		.dout       (dout),
		.dataout    (dataout)
	);

endmodule

// File: hw/port_readback.sv
`timescale 1ns/10ps

module port_readback
	import zports_pkg::*;
(
	port_bus_if.res    bus,
	input  logic [4:0] keys_in,
	input  logic [7:0] mus_in,
	input  logic [7:0] sd_dataout,
	input  logic [5:0] border,
	input  logic [7:0] xt_addr,
	input  logic       iorq_n,
	input  logic       rd_n,
	output logic [7:0] dout,
	output logic       dataout
);

	// read data mux
	always_comb
	begin
		case (bus.sel)
		PSEL_FE:
			dout = {3'b100, keys_in}; // tape in reads as 0
		PSEL_MOUSE:
			dout = mus_in;
		PSEL_SDCFG:
			dout = 8'h00; // card present, not write protected
		PSEL_SDDAT:
			dout = sd_dataout;
		PSEL_XTRD:
		begin
			// only the border register has read-back
			if (xt_addr == XREG_BORDER)
				dout = {2'b00, border};
			else
				dout = 8'hFF;
		end
		default:
			dout = 8'hFF;
		endcase
	end

	// drive the Z80 data bus only on a decoded read
	assign dataout = (bus.sel != PSEL_NONE) & ~iorq_n & ~rd_n;

endmodule

// File: hw/port_regs.sv
`timescale 1ns/10ps

module port_regs
	import zports_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	port_bus_if.exe    bus,
	output logic [5:0] border,
	output logic [7:0] vcfg,
	output logic [7:0] psd0,
	output logic [7:0] psd1,
	output logic [7:0] psd2,
	output logic [7:0] psd3,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic       sdcs_n,
	output logic       sd_start,
	output logic [7:0] sd_datain,
	output logic [7:0] xt_addr
);

	xt_state_e  xt_state;
	logic [7:0] p7ffd_q;
	logic [7:0] peff7_q;
	logic       block1m;
	logic       lock7ffd;
	logic       sddat_acc;

	assign block1m   = peff7_q[2];
	assign lock7ffd  = p7ffd_q[5] & block1m; // 48k lock
	assign sddat_acc = (bus.wr_stb | bus.rd_stb) && (bus.sel == PSEL_SDDAT);

	// border, beeper, DACs and extension registers
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			vcfg   <= '0;
			psd0   <= '0;
			psd1   <= '0;
			psd2   <= '0;
			psd3   <= '0;
		end
		else if (bus.wr_stb)
		begin
			case (bus.sel)
			PSEL_FE:
			begin
				border <= {bus.data[1], 1'b0, bus.data[2], 1'b0, bus.data[0], 1'b0};
				psd0   <= {8{bus.data[4]}}; // beeper drives all DACs
				psd1   <= {8{bus.data[4]}};
				psd2   <= {8{bus.data[4]}};
				psd3   <= {8{bus.data[4]}};
			end
			PSEL_COVOX:
			begin
				psd0 <= bus.data;
				psd1 <= bus.data;
				psd2 <= bus.data;
				psd3 <= bus.data;
			end
			PSEL_SD0:
				psd0 <= bus.data;
			PSEL_SD1:
				psd1 <= bus.data;
			PSEL_SD2:
				psd2 <= bus.data;
			PSEL_SD3:
				psd3 <= bus.data;
			PSEL_XT:
			begin
				if (xt_state == XT_DATA)
				begin
					case (xt_addr)
					XREG_BORDER:
						border <= bus.data[5:0];
					XREG_VCFG:
						vcfg <= bus.data;
					default:
						;
					endcase
				end
			end
			default:
				;
			endcase
		end
	end

	// paging ports, EFF7 decoded koe style on a12
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= '0;
			peff7_q <= '0;
		end
		else if (bus.wr_stb)
		begin
			if (bus.sel == PSEL_7FFD && !lock7ffd)
				p7ffd_q <= bus.data;
			if (bus.sel == PSEL_EFF7 && !bus.a_hi[4])
				peff7_q <= bus.data;
		end
	end

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	// 55FF unlock sequence: key, index, data
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			xt_state <= XT_LOCKED;
		else if (bus.wr_stb)
		begin
			case (xt_state)
			XT_LOCKED:
			begin
				if (bus.sel == PSEL_XT && bus.data == XT_KEY)
					xt_state <= XT_ADDR;
			end
			XT_ADDR:
				xt_state <= (bus.sel == PSEL_XT) ? XT_DATA : XT_LOCKED;
			default:
				xt_state <= XT_LOCKED; // data written or sequence broken
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.wr_stb && bus.sel == PSEL_XT && xt_state == XT_ADDR)
			xt_addr <= bus.data;
	end

	// SD card control
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sdcs_n   <= 1'b1;
			sd_start <= 1'b0;
		end
		else
		begin
			sd_start <= sddat_acc; // strobe is one clock wide
			if (bus.wr_stb && bus.sel == PSEL_SDCFG)
				sdcs_n <= bus.data[1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (sddat_acc)
			sd_datain <= bus.wr_stb ? bus.data : 8'hFF; // FF clocks in on reads
	end

endmodule

// File: hw/port_decode.sv
`timescale 1ns/10ps

module port_decode
	import zports_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [7:0]  din,
	output logic        porthit,
	port_bus_if.dec     bus
);

	logic io_wr;
	logic io_rd;
	logic armed; // iorq_n seen high since the last strobe

	assign io_wr = ~iorq_n & ~wr_n;
	assign io_rd = ~iorq_n & ~rd_n;

	// address match
	always_comb
	begin
		bus.sel = PSEL_NONE;
		if (a == XT_PORT)
			bus.sel = PSEL_XT;
		else
		begin
			case (a[7:0])
			PORT_FE:
				bus.sel = PSEL_FE;
			PORT_7FFD:
			begin
				if (!a[15]) // 7FFD only, FFFD/BFFD belong to the AY
					bus.sel = PSEL_7FFD;
			end
			PORT_EFF7:
				bus.sel = PSEL_EFF7;
			PORT_CVX1, PORT_CVX2:
				bus.sel = PSEL_COVOX;
			PORT_SD0:
				bus.sel = PSEL_SD0;
			PORT_SD1:
				bus.sel = PSEL_SD1;
			PORT_SD2:
				bus.sel = PSEL_SD2;
			PORT_SD3:
				bus.sel = PSEL_SD3;
			PORT_XTRD:
				bus.sel = PSEL_XTRD;
			PORT_SDCFG:
				bus.sel = PSEL_SDCFG;
			PORT_SDDAT:
				bus.sel = PSEL_SDDAT;
			PORT_MOUSE:
				bus.sel = PSEL_MOUSE;
			default:
				bus.sel = PSEL_NONE;
			endcase
		end
	end

	assign porthit  = (bus.sel != PSEL_NONE);
	assign bus.data = din;
	assign bus.a_hi = a[15:8];

	// one strobe per iorq_n low period
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			armed      <= 1'b1; // bus assumed idle out of reset
			bus.wr_stb <= 1'b0;
			bus.rd_stb <= 1'b0;
		end
		else
		begin
			bus.wr_stb <= armed & io_wr;
			bus.rd_stb <= armed & io_rd;
			if (iorq_n)
				armed <= 1'b1;
			else if (io_wr || io_rd)
				armed <= 1'b0;
		end
	end

endmodule

// File: hw/port_bus_if.sv
`timescale 1ns/10ps

interface port_bus_if
	import zports_pkg::*;
();

	port_sel_e  sel;     // combinational from the current address
	logic       wr_stb;  // one clock per I/O write cycle
	logic       rd_stb;  // one clock per I/O read cycle
	logic [7:0] data;    // din as seen on the bus
	logic [7:0] a_hi;    // upper address byte

	modport dec
	(
		output sel,
		output wr_stb,
		output rd_stb,
		output data,
		output a_hi
	);

	// register stage needs everything
	modport exe
	(
		input sel,
		input wr_stb,
		input rd_stb,
		input data,
		input a_hi
	);

	modport res
	(
		input sel
	);

endinterface

// File: hw/zports_pkg.sv
package zports_pkg;

	// which port the current I/O cycle targets
	typedef enum logic [3:0]
	{
		PSEL_NONE,
		PSEL_FE,
		PSEL_7FFD,
		PSEL_EFF7,
		PSEL_COVOX,  // FB or DD
		PSEL_SD0,
		PSEL_SD1,
		PSEL_SD2,
		PSEL_SD3,
		PSEL_XT,     // 55FF, full address
		PSEL_XTRD,
		PSEL_SDCFG,
		PSEL_SDDAT,
		PSEL_MOUSE
	} port_sel_e;

	// 55FF extension port sequencing
	typedef enum logic [1:0]
	{
		XT_LOCKED,
		XT_ADDR,
		XT_DATA
	} xt_state_e;

	// low address byte of each port
	localparam logic [7:0] PORT_FE    = 8'hFE;
	localparam logic [7:0] PORT_7FFD  = 8'hFD;
	localparam logic [7:0] PORT_EFF7  = 8'hF7;
	localparam logic [7:0] PORT_CVX1  = 8'hFB;
	localparam logic [7:0] PORT_CVX2  = 8'hDD;
	localparam logic [7:0] PORT_SD0   = 8'h0F;
	localparam logic [7:0] PORT_SD1   = 8'h1F;
	localparam logic [7:0] PORT_SD2   = 8'h4F;
	localparam logic [7:0] PORT_SD3   = 8'h5F;
	localparam logic [7:0] PORT_XTRD  = 8'hEF;
	localparam logic [7:0] PORT_SDCFG = 8'h77;
	localparam logic [7:0] PORT_SDDAT = 8'h57;
	localparam logic [7:0] PORT_MOUSE = 8'hDF;

	localparam logic [15:0] XT_PORT = 16'h55FF; // decoded on all 16 bits

	localparam logic [7:0] XT_KEY = 8'hAA; // unlock value

	// extension register indices
	localparam logic [7:0] XREG_BORDER = 8'h00;
	localparam logic [7:0] XREG_VCFG   = 8'h08;

endpackage
